/* rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Operator codes for the ALU, one per supported operation
    typedef enum logic [4:0] {
        ALU_ADD   = 5'd0,
        ALU_SUB   = 5'd1,
        ALU_XOR   = 5'd2,
        ALU_OR    = 5'd3,
        ALU_SLL   = 5'd4,
        ALU_SRL   = 5'd5,
        ALU_SRA   = 5'd6,
        ALU_SLT   = 5'd7,
        ALU_SLTU  = 5'd8,
        ALU_MUL   = 5'd9,
        ALU_MULH  = 5'd10,
        ALU_MULU  = 5'd11,
        ALU_MULHU = 5'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2
    } branch_e;

    typedef struct packed {
        alu_op_e   op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        logic      use_imm;   // Operand 2 comes from imm instead of rs2
        logic      write_en;
        branch_e   branch;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
        logic      zero;
        logic      write_en;
        branch_e   branch;
        logic      illegal;
    } executed_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
        logic      write_en;
        logic      taken;
        logic      illegal;
    } result_t;

endpackage

`default_nettype wire

/* rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_exec_pkg::alu_op_e operator,
    input  rv_exec_pkg::word_t   operand1,
    input  rv_exec_pkg::word_t   operand2,
    output rv_exec_pkg::word_t   result,
    output logic                 result_is_zero
);
    import rv_exec_pkg::*;

    logic [63:0] signed_product;
    logic [63:0] unsigned_product;
    logic [4:0]  shamt;

    // Both products are formed every cycle, the operator picks a half
    assign signed_product   = $signed(operand1) * $signed(operand2);
    assign unsigned_product = operand1 * operand2;

    assign shamt = operand2[4:0];  // Only the low five bits count for shifts

    always_comb begin
        case (operator)
            ALU_ADD: begin
                result = operand1 + operand2;
            end
            ALU_SUB: begin
                result = operand1 - operand2;
            end
            ALU_XOR: begin
                result = operand1 ^ operand2;
            end
            ALU_OR: begin
                result = operand1 | operand2;
            end
            ALU_SLL: begin
                result = operand1 << shamt;
            end
            ALU_SRL: begin
                result = operand1 >> shamt;
            end
            ALU_SRA: begin
                result = $signed(operand1) >>> shamt;
            end
            ALU_SLT: begin
                result = ($signed(operand1) < $signed(operand2)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                result = (operand1 < operand2) ? 32'd1 : 32'd0;
            end
            ALU_MUL:   result = signed_product[31:0];
            ALU_MULH:  result = signed_product[63:32];
            ALU_MULU:  result = unsigned_product[31:0];
            ALU_MULHU: result = unsigned_product[63:32];
            default:   result = '0;
        endcase
    end

    assign result_is_zero = (result == '0);

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_exec_pkg::reg_addr_t rd_addr1,
    input  rv_exec_pkg::reg_addr_t rd_addr2,
    input  logic                   wr_en,
    input  rv_exec_pkg::reg_addr_t wr_addr,
    input  rv_exec_pkg::word_t     wr_data,
    output rv_exec_pkg::word_t     rd_data1,
    output rv_exec_pkg::word_t     rd_data2
);
    import rv_exec_pkg::*;

    word_t regs [1:31];  // No storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads are asynchronous and see x0 as zero
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

`default_nettype wire

/* rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder #(
    parameter int QUEUE_DEPTH = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  rv_exec_pkg::word_t    in_instr,
    input  logic                  dec_ready,
    output logic                  in_ready,
    output logic                  dec_valid,
    output rv_exec_pkg::decoded_t dec_op
);
    import rv_exec_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(QUEUE_DEPTH);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    decoded_t         dec_next;
    decoded_t         queue [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign opcode = in_instr[6:0];
    assign funct3 = in_instr[14:12];
    assign funct7 = in_instr[31:25];

    always_comb begin
        dec_next.op       = ALU_ADD;
        dec_next.rs1      = in_instr[19:15];
        dec_next.rs2      = in_instr[24:20];
        dec_next.rd       = in_instr[11:7];
        dec_next.imm      = {{20{in_instr[31]}}, in_instr[31:20]};
        dec_next.use_imm  = 1'b0;
        dec_next.write_en = 1'b0;
        dec_next.branch   = BR_NONE;
        dec_next.illegal  = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_next.write_en = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   dec_next.op = ALU_ADD;
                    {F7_ALT, 3'b000}:    dec_next.op = ALU_SUB;
                    {F7_BASE, 3'b001}:   dec_next.op = ALU_SLL;
                    {F7_BASE, 3'b010}:   dec_next.op = ALU_SLT;
                    {F7_BASE, 3'b011}:   dec_next.op = ALU_SLTU;
                    {F7_BASE, 3'b100}:   dec_next.op = ALU_XOR;
                    {F7_BASE, 3'b101}:   dec_next.op = ALU_SRL;
                    {F7_ALT, 3'b101}:    dec_next.op = ALU_SRA;
                    {F7_BASE, 3'b110}:   dec_next.op = ALU_OR;
                    {F7_MULDIV, 3'b000}: dec_next.op = ALU_MUL;
                    {F7_MULDIV, 3'b001}: dec_next.op = ALU_MULH;
                    {F7_MULDIV, 3'b010}: dec_next.op = ALU_MULU;  // Takes the MULHSU slot
                    {F7_MULDIV, 3'b011}: dec_next.op = ALU_MULHU;
                    default:             dec_next.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                dec_next.write_en = 1'b1;
                dec_next.use_imm  = 1'b1;
                case (funct3)
                    3'b000: dec_next.op = ALU_ADD;
                    3'b010: dec_next.op = ALU_SLT;
                    3'b011: dec_next.op = ALU_SLTU;
                    3'b100: dec_next.op = ALU_XOR;
                    3'b110: dec_next.op = ALU_OR;
                    3'b001: begin
                        dec_next.op      = ALU_SLL;
                        dec_next.imm     = {27'b0, in_instr[24:20]};
                        dec_next.illegal = (funct7 != F7_BASE);
                    end
                    3'b101: begin
                        dec_next.op      = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        dec_next.imm     = {27'b0, in_instr[24:20]};
                        dec_next.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                    end
                    default: dec_next.illegal = 1'b1;  // ANDI is not supported
                endcase
            end
            OPC_BRANCH: begin
                dec_next.op  = ALU_SUB;  // Zero flag tells equality
                dec_next.imm = {{19{in_instr[31]}}, in_instr[31], in_instr[7],
                                in_instr[30:25], in_instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  dec_next.branch = BR_EQ;
                    3'b001:  dec_next.branch = BR_NE;
                    default: dec_next.illegal = 1'b1;
                endcase
            end
            default: dec_next.illegal = 1'b1;
        endcase
        if (dec_next.illegal) begin
            dec_next.write_en = 1'b0;
        end
    end

    assign dec_valid = (count != '0);
    assign dec_op    = queue[rd_ptr];
    assign pop       = dec_valid && dec_ready;
    assign in_ready  = (count != FULL_COUNT) || pop;  // Combinational through the chain
    assign push      = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= dec_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dec_valid,
    input  rv_exec_pkg::decoded_t  dec_op,
    input  logic                   ex_ready,
    input  logic                   wr_en,
    input  rv_exec_pkg::reg_addr_t wr_addr,
    input  rv_exec_pkg::word_t     wr_data,
    output logic                   dec_ready,
    output logic                   ex_valid,
    output rv_exec_pkg::executed_t ex_out
);
    import rv_exec_pkg::*;

    word_t rf_data1;
    word_t rf_data2;
    word_t operand1;
    word_t src2;
    word_t operand2;
    word_t alu_result;
    logic  alu_zero;
    logic  fwd_ok;
    logic  load;

    rv_regfile rv_regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (dec_op.rs1),
        .rd_addr2 (dec_op.rs2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2)
    );

    // Only the entry in our own register can be newer than the register file
    assign fwd_ok   = ex_valid && ex_out.write_en && (ex_out.rd != '0);
    assign operand1 = (fwd_ok && (ex_out.rd == dec_op.rs1)) ? ex_out.value : rf_data1;
    assign src2     = (fwd_ok && (ex_out.rd == dec_op.rs2)) ? ex_out.value : rf_data2;
    assign operand2 = dec_op.use_imm ? dec_op.imm : src2;

    rv_alu rv_alu_i (
        .operator       (dec_op.op),
        .operand1       (operand1),
        .operand2       (operand2),
        .result         (alu_result),
        .result_is_zero (alu_zero)
    );

    assign dec_ready = !ex_valid || ex_ready;
    assign load      = dec_valid && dec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (dec_ready) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex_out.rd       <= dec_op.rd;
            ex_out.value    <= alu_result;
            ex_out.zero     <= alu_zero;
            ex_out.write_en <= dec_op.write_en;
            ex_out.branch   <= dec_op.branch;
            ex_out.illegal  <= dec_op.illegal;
        end
    end

endmodule

`default_nettype wire

/* rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ex_valid,
    input  rv_exec_pkg::executed_t ex_out,
    input  logic                   out_ready,
    output logic                   ex_ready,
    output logic                   out_valid,
    output rv_exec_pkg::result_t   out_result,
    output logic                   wr_en,
    output rv_exec_pkg::reg_addr_t wr_addr,
    output rv_exec_pkg::word_t     wr_data
);
    import rv_exec_pkg::*;

    logic capture;
    logic taken;

    assign ex_ready = !out_valid || out_ready;
    assign capture  = ex_valid && ex_ready;

    always_comb begin
        case (ex_out.branch)
            BR_EQ:   taken = ex_out.zero;
            BR_NE:   taken = !ex_out.zero;
            default: taken = 1'b0;
        endcase
    end

    // The register file takes the write on the same edge that captures here
    assign wr_en   = capture && ex_out.write_en;
    assign wr_addr = ex_out.rd;
    assign wr_data = ex_out.value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (ex_ready) begin
            out_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            out_result.rd       <= ex_out.rd;
            out_result.value    <= ex_out.value;  // Kept for branches and illegal words
            out_result.write_en <= ex_out.write_en;
            out_result.taken    <= taken;
            out_result.illegal  <= ex_out.illegal;
        end
    end

endmodule

`default_nettype wire

/* rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top #(
    parameter int QUEUE_DEPTH = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  rv_exec_pkg::word_t   in_instr,
    input  logic                 out_ready,
    output logic                 in_ready,
    output logic                 out_valid,
    output rv_exec_pkg::result_t out_result
);
    import rv_exec_pkg::*;

    logic      dec_valid;
    logic      dec_ready;
    decoded_t  dec_op;
    logic      ex_valid;
    logic      ex_ready;
    executed_t ex_out;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    rv_decoder #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) rv_decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .dec_ready (dec_ready),
        .in_ready  (in_ready),
        .dec_valid (dec_valid),
        .dec_op    (dec_op)
    );

    rv_execute rv_execute_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .ex_ready  (ex_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .dec_ready (dec_ready),
        .ex_valid  (ex_valid),
        .ex_out    (ex_out)
    );

    rv_result rv_result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_out     (ex_out),
        .out_ready  (out_ready),
        .ex_ready   (ex_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

`default_nettype wire

/* rv_exec_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic                 in_ready,
    input rv_exec_pkg::word_t   in_instr,
    input logic                 out_valid,
    input logic                 out_ready,
    input rv_exec_pkg::result_t out_result
);

    int assert_failures = 0;  // Read by the testbench at the end of the run

    in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_instr))
        else begin
            assert_failures++;
            $error("in_valid fell or in_instr changed before in_ready");
        end

    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else begin
            assert_failures++;
            $error("out_valid fell or out_result changed before out_ready");
        end

    // Async reset clears the output register right away
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            assert_failures++;
            $error("out_valid is high while rst_n is low");
        end

    illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_result.illegal |-> !out_result.write_en)
        else begin
            assert_failures++;
            $error("An illegal result carries write_en");
        end

endmodule

bind rv_exec_top rv_exec_properties rv_exec_properties_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_instr   (in_instr),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
);

`default_nettype wire

/* rv_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam int    QUEUE_DEPTH     = 1;
    localparam int    RESET_CYCLES    = 16;
    localparam int    CYCLES_PER_LINE = 40;
    localparam string STIM_FILE       = "rv_exec_stimulus.txt";

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    word_t   in_instr;
    logic    out_ready;
    logic    in_ready;
    logic    out_valid;
    result_t out_result;

    string   tag_q[$];
    word_t   instr_q[$];
    result_t exp_q[$];
    int      n_tests;
    int      n_failed_tests;
    int      n_mismatches;
    int      n_assert;
    int      run;
    bit      stall_mode;
    bit      loaded;
    bit      test_ok;

    rv_exec_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) rv_exec_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    always #10 clk = ~clk;

    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        string       tag;
        word_t       instr;
        word_t       value;
        logic [31:0] rd_f;
        logic [31:0] wr_f;
        logic [31:0] tk_f;
        logic [31:0] il_f;
        result_t     exp;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%s %h %h %h %h %h %h",
                                   tag, instr, rd_f, value, wr_f, tk_f, il_f);
                    if (code == 7) begin
                        exp.rd       = rd_f[4:0];
                        exp.value    = value;
                        exp.write_en = wr_f[0];
                        exp.taken    = tk_f[0];
                        exp.illegal  = il_f[0];
                        tag_q.push_back(tag);
                        instr_q.push_back(instr);
                        exp_q.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            n_mismatches++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got x%0d expected x%0d", $time, name, got, exp);
            n_mismatches++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            n_mismatches++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_entry(input int idx);
        result_t exp;
        exp     = exp_q[idx];
        test_ok = 1'b1;
        check_reg("out_result.rd", out_result.rd, exp.rd);
        if (!exp.illegal) begin
            check_word("out_result.value", out_result.value, exp.value);  // Undefined if illegal
        end
        check_flag("out_result.write_en", out_result.write_en, exp.write_en);
        check_flag("out_result.taken", out_result.taken, exp.taken);
        check_flag("out_result.illegal", out_result.illegal, exp.illegal);
        n_tests++;
        if (!test_ok) begin
            n_failed_tests++;
        end
        $display("test %0d %s run %0d instr %h: %s", idx, tag_q[idx], run, instr_q[idx],
                 test_ok ? "ok" : "FAILED");
    endtask

    // Keeps in_valid up and the word stable until in_ready is seen at an edge
    task automatic drive_instructions();
        int idx;
        idx = 0;
        in_instr <= instr_q[0];
        in_valid <= 1'b1;
        while (idx < instr_q.size()) begin
            @(posedge clk);
            if (in_ready) begin
                idx++;
                if (idx < instr_q.size()) begin
                    in_instr <= instr_q[idx];
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic collect_results();
        int idx;
        idx = 0;
        while (idx < exp_q.size()) begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                check_entry(idx);
                idx++;
            end
            out_ready <= stall_mode ? ($urandom % 3 != 0) : 1'b1;
        end
        out_ready <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (out_valid) begin
                $display("An extra result appeared after the last expected one in run %0d", run);
                n_failed_tests++;
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b1;
        in_valid       = 1'b0;
        in_instr       = '0;
        out_ready      = 1'b1;
        n_tests        = 0;
        n_failed_tests = 0;
        n_mismatches   = 0;
        stall_mode     = 1'b0;
        void'($urandom(32'h86b1_52f9));
        load_stimulus();
        loaded = 1'b1;
        if (instr_q.size() == 0) begin
            $display("No stimulus entries were read, so nothing was tested");
            n_failed_tests++;
        end else begin
            // Run 0 streams freely, run 1 repeats the program under random stalls
            for (run = 0; run < 2; run++) begin
                stall_mode = (run == 1);
                apply_reset();
                // The pipeline comes out of reset empty and ready
                check_flag("in_ready", in_ready, 1'b1);
                check_flag("out_valid", out_valid, 1'b0);
                fork
                    drive_instructions();
                    collect_results();
                join
            end
        end
        n_assert = rv_exec_top_i.rv_exec_properties_i.assert_failures;
        $display("Summary: %0d results, %0d tests with errors, %0d mismatches, %0d assertion errors",
                 n_tests, n_failed_tests, n_mismatches, n_assert);
        if (n_failed_tests == 0 && n_mismatches == 0 && n_assert == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = 2 * (RESET_CYCLES + 8 + CYCLES_PER_LINE * instr_q.size());
        repeat (limit) @(posedge clk);
        $display("Timeout: the pipeline did not return all results within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_exec_stimulus.txt */
# tag instr rd value write_en taken illegal, all numbers in hex
# value is not compared on rows with illegal set
arith   06400093 01 00000064 1 0 0
arith   fff00113 02 ffffffff 1 0 0
arith   002081b3 03 00000063 1 0 0
arith   40100233 04 ffffff9c 1 0 0
arith   002102b3 05 fffffffe 1 0 0
arith   0040c333 06 fffffff8 1 0 0
arith   0040e3b3 07 fffffffc 1 0 0
shift   00409413 08 00000640 1 0 0
shift   405254b3 09 ffffffff 1 0 0
shift   40425593 0b fffffff9 1 0 0
compare 00122633 0c 00000001 1 0 0
compare 001236b3 0d 00000000 1 0 0
mul     02120733 0e ffffd8f0 1 0 0
mul     021217b3 0f ffffffff 1 0 0
mul     02123833 10 00000063 1 0 0
mul     022128b3 11 00000001 1 0 0
dep     00500013 00 00000005 1 0 0
dep     00000933 12 00000000 1 0 0
dep     ffc08993 13 00000060 1 0 0
dep     01398a33 14 000000c0 1 0 0
dep     413a0ab3 15 00000060 1 0 0
branch  03598063 00 00000000 0 1 0
branch  04209063 00 00000065 0 1 0
branch  04208063 00 00000065 0 0 0
illegal 123450b7 01 00000000 0 0 1
illegal 0020fb33 16 00000000 0 0 1
illegal 00008c33 18 00000064 1 0 0
illegal 000b0bb3 17 00000000 1 0 0

/* rv_exec_top.f */
rv_exec_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_decoder.sv
rv_execute.sv
rv_result.sv
rv_exec_top.sv
rv_exec_properties.sv
rv_exec_tb.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - files:
      - rv_exec_pkg.sv
      - rv_alu.sv
      - rv_regfile.sv
      - rv_decoder.sv
      - rv_execute.sv
      - rv_result.sv
      - rv_exec_top.sv
  - target: test
    files:
      - rv_exec_properties.sv
      - rv_exec_tb.sv
